//--- hw/core_pkg.sv
package core_pkg;

    localparam int XLEN = 32;
    localparam int NREGS = 16;
    localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

    // internal opcodes after decode
    typedef enum logic [4:0] {
        OP_LUI,
        OP_ADDI,
        OP_ANDI,
        OP_ORI,
        OP_XORI,
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLT,
        OP_LW,
        OP_SW,
        OP_BEQ,
        OP_BNE,
        OP_JAL,
        OP_ILLEGAL
    } op_e;

    // per-instruction phases of the multicycle core
    typedef enum logic [1:0] {
        PH_FETCH,
        PH_EXEC,
        PH_MEM,
        PH_WB
    } phase_e;

    typedef struct packed {
        op_e             op;
        logic [3:0]      rd;
        logic [3:0]      rs1;
        logic [3:0]      rs2;
        logic [XLEN-1:0] imm;
        logic            writes_rd;
    } decoded_t;

    typedef struct packed {
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] wdata;
        logic            we;
    } mem_req_t;

    // trace record of one completed instruction
    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [3:0]      rd;
        logic [XLEN-1:0] wdata;
        logic            wen;
    } retire_t;

endpackage

//--- hw/core_ifu.sv
`timescale 1ns/1ps

module core_ifu (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic [core_pkg::XLEN-1:0] pc,
    input  logic                      fetch_start,
    output logic                      fetch_req,
    output logic [core_pkg::XLEN-1:0] fetch_addr,
    input  logic                      fetch_done,
    input  logic [core_pkg::XLEN-1:0] fetch_rdata,
    output logic [core_pkg::XLEN-1:0] inst
);

    // request stays up until the response comes back
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fetch_req <= 1'b0;
        end else if (fetch_start) begin
            fetch_req <= 1'b1;
        end else if (fetch_done) begin
            fetch_req <= 1'b0;
        end
    end

    // fetch address and instruction word, held for decode
    always_ff @(posedge clk) begin
        if (fetch_start) begin
            fetch_addr <= pc;
        end
        if (fetch_done) begin
            inst <= fetch_rdata;
        end
    end

    // pc unit must not start a new fetch while one is in flight
    a_no_restart: assert property (@(posedge clk) disable iff (!arst_n)
        fetch_start |-> !fetch_req);

endmodule

//--- hw/core_idu.sv
`timescale 1ns/1ps

module core_idu (
    input  logic [core_pkg::XLEN-1:0] inst,
    output core_pkg::decoded_t        dec
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    core_pkg::op_e op_raw;
    logic bad_idx;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    // major opcode plus funct fields
    always_comb begin
        op_raw = core_pkg::OP_ILLEGAL;
        case (opcode)
            7'b0110111: op_raw = core_pkg::OP_LUI;
            7'b1101111: op_raw = core_pkg::OP_JAL;
            7'b0010011: begin
                case (funct3)
                    3'b000: op_raw = core_pkg::OP_ADDI;
                    3'b100: op_raw = core_pkg::OP_XORI;
                    3'b110: op_raw = core_pkg::OP_ORI;
                    3'b111: op_raw = core_pkg::OP_ANDI;
                    default: op_raw = core_pkg::OP_ILLEGAL;
                endcase
            end
            7'b0110011: begin
                if (funct7 == 7'b0000000) begin
                    case (funct3)
                        3'b000: op_raw = core_pkg::OP_ADD;
                        3'b010: op_raw = core_pkg::OP_SLT;
                        3'b100: op_raw = core_pkg::OP_XOR;
                        3'b110: op_raw = core_pkg::OP_OR;
                        3'b111: op_raw = core_pkg::OP_AND;
                        default: op_raw = core_pkg::OP_ILLEGAL;
                    endcase
                end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
                    op_raw = core_pkg::OP_SUB;
                end
            end
            7'b0000011: if (funct3 == 3'b010) op_raw = core_pkg::OP_LW;
            7'b0100011: if (funct3 == 3'b010) op_raw = core_pkg::OP_SW;
            7'b1100011: begin
                if (funct3 == 3'b000) begin
                    op_raw = core_pkg::OP_BEQ;
                end else if (funct3 == 3'b001) begin
                    op_raw = core_pkg::OP_BNE;
                end
            end
            default: op_raw = core_pkg::OP_ILLEGAL;
        endcase
    end

    // RV32E has x0..x15, so bit 4 of any used index is illegal
    always_comb begin
        case (op_raw)
            core_pkg::OP_LUI, core_pkg::OP_JAL:
                bad_idx = inst[11];
            core_pkg::OP_ADDI, core_pkg::OP_ANDI, core_pkg::OP_ORI,
            core_pkg::OP_XORI, core_pkg::OP_LW:
                bad_idx = inst[11] | inst[19];
            core_pkg::OP_SW, core_pkg::OP_BEQ, core_pkg::OP_BNE:
                bad_idx = inst[19] | inst[24];
            default:
                bad_idx = inst[11] | inst[19] | inst[24];
        endcase
    end

    always_comb begin
        dec.op  = bad_idx ? core_pkg::OP_ILLEGAL : op_raw;
        dec.rd  = inst[10:7];
        dec.rs1 = inst[18:15];
        dec.rs2 = inst[23:20];
        case (dec.op)
            core_pkg::OP_LUI:
                dec.imm = {inst[31:12], 12'b0};
            core_pkg::OP_SW:
                dec.imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            core_pkg::OP_BEQ, core_pkg::OP_BNE:
                dec.imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            core_pkg::OP_JAL:
                dec.imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
            default:
                dec.imm = {{20{inst[31]}}, inst[31:20]};
        endcase
        // stores, branches, illegal ops and rd = x0 leave the register file alone
        dec.writes_rd = (dec.rd != 4'd0)
                      && (dec.op != core_pkg::OP_SW)
                      && (dec.op != core_pkg::OP_BEQ)
                      && (dec.op != core_pkg::OP_BNE)
                      && (dec.op != core_pkg::OP_ILLEGAL);
    end

endmodule

//--- hw/core_regfile.sv
`timescale 1ns/1ps

module core_regfile (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic [3:0]                raddr1,
    input  logic [3:0]                raddr2,
    output logic [core_pkg::XLEN-1:0] rdata1,
    output logic [core_pkg::XLEN-1:0] rdata2,
    input  logic                      wen,
    input  logic [3:0]                waddr,
    input  logic [core_pkg::XLEN-1:0] wdata
);

    logic [core_pkg::XLEN-1:0] regs [core_pkg::NREGS];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < core_pkg::NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && waddr != 4'd0) begin
            regs[waddr] <= wdata;
        end
    end

    // x0 is never written, so it stays zero from reset
    assign rdata1 = regs[raddr1];
    assign rdata2 = regs[raddr2];

endmodule

//--- hw/core_exu.sv
`timescale 1ns/1ps

module core_exu (
    input  core_pkg::decoded_t        dec,
    input  logic [core_pkg::XLEN-1:0] pc,
    input  logic [core_pkg::XLEN-1:0] rs1_data,
    input  logic [core_pkg::XLEN-1:0] rs2_data,
    output logic [core_pkg::XLEN-1:0] alu_result,
    output logic [core_pkg::XLEN-1:0] mem_addr,
    output logic                      taken,
    output logic [core_pkg::XLEN-1:0] next_pc
);

    logic [core_pkg::XLEN-1:0] pc_plus4;
    logic                      rs_equal;

    assign pc_plus4 = pc + 32'd4;
    assign rs_equal = (rs1_data == rs2_data);
    assign mem_addr = rs1_data + dec.imm;

    always_comb begin
        case (dec.op)
            core_pkg::OP_LUI:  alu_result = dec.imm;
            core_pkg::OP_ADDI: alu_result = rs1_data + dec.imm;
            core_pkg::OP_ANDI: alu_result = rs1_data & dec.imm;
            core_pkg::OP_ORI:  alu_result = rs1_data | dec.imm;
            core_pkg::OP_XORI: alu_result = rs1_data ^ dec.imm;
            core_pkg::OP_ADD:  alu_result = rs1_data + rs2_data;
            core_pkg::OP_SUB:  alu_result = rs1_data - rs2_data;
            core_pkg::OP_AND:  alu_result = rs1_data & rs2_data;
            core_pkg::OP_OR:   alu_result = rs1_data | rs2_data;
            core_pkg::OP_XOR:  alu_result = rs1_data ^ rs2_data;
            core_pkg::OP_SLT:
                alu_result = {31'b0, $signed(rs1_data) < $signed(rs2_data)};
            // link address
            core_pkg::OP_JAL:  alu_result = pc_plus4;
            default:           alu_result = '0;
        endcase
    end

    // branch decision
    always_comb begin
        case (dec.op)
            core_pkg::OP_JAL: taken = 1'b1;
            core_pkg::OP_BEQ: taken = rs_equal;
            core_pkg::OP_BNE: taken = !rs_equal;
            default:          taken = 1'b0;
        endcase
    end

    assign next_pc = taken ? pc + dec.imm : pc_plus4;

endmodule

//--- hw/core_lsu.sv
`timescale 1ns/1ps

module core_lsu (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      fetch_req,
    input  logic [core_pkg::XLEN-1:0] fetch_addr,
    output logic                      fetch_done,
    input  logic                      data_req,
    input  core_pkg::mem_req_t        data_req_info,
    output logic                      data_done,
    output logic [core_pkg::XLEN-1:0] rdata,
    output core_pkg::mem_req_t        mem_req,
    output logic                      mem_req_valid,
    input  logic                      mem_req_ready,
    input  logic                      mem_rsp_valid,
    input  logic [core_pkg::XLEN-1:0] mem_rsp_rdata
);

    logic busy;
    logic owner_data;
    logic take;

    // new request only when nothing is in flight
    assign take = !busy && (fetch_req || data_req);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mem_req_valid <= 1'b0;
            busy          <= 1'b0;
            owner_data    <= 1'b0;
        end else begin
            if (take) begin
                mem_req_valid <= 1'b1;
                busy          <= 1'b1;
                owner_data    <= data_req;
            end else if (mem_req_valid && mem_req_ready) begin
                mem_req_valid <= 1'b0;
            end
            if (mem_rsp_valid) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            if (data_req) begin
                mem_req <= data_req_info;
            end else begin
                mem_req <= '{addr: fetch_addr, wdata: '0, we: 1'b0};
            end
        end
    end

    // response goes back to whoever issued the access
    assign fetch_done = mem_rsp_valid && !owner_data;
    assign data_done  = mem_rsp_valid && owner_data;
    assign rdata      = mem_rsp_rdata;

    a_req_stable: assert property (@(posedge clk) disable iff (!arst_n)
        mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req));

    a_rsp_outstanding: assert property (@(posedge clk) disable iff (!arst_n)
        mem_rsp_valid |-> busy && !mem_req_valid);

    a_one_source: assert property (@(posedge clk) disable iff (!arst_n)
        !(fetch_req && data_req));

endmodule

//--- hw/core_pcu.sv
`timescale 1ns/1ps

module core_pcu (
    input  logic                      clk,
    input  logic                      arst_n,
    input  core_pkg::decoded_t        dec,
    input  logic [core_pkg::XLEN-1:0] alu_result,
    input  logic [core_pkg::XLEN-1:0] mem_addr,
    input  logic [core_pkg::XLEN-1:0] rs2_data,
    input  logic [core_pkg::XLEN-1:0] next_pc,
    output logic                      fetch_start,
    input  logic                      fetch_done,
    output logic                      data_req,
    output core_pkg::mem_req_t        data_req_info,
    input  logic                      data_done,
    input  logic [core_pkg::XLEN-1:0] data_rdata,
    output logic [core_pkg::XLEN-1:0] pc,
    output logic                      rf_wen,
    output logic [3:0]                rf_waddr,
    output logic [core_pkg::XLEN-1:0] rf_wdata,
    output logic                      retire_valid,
    output core_pkg::retire_t         retire
);

    core_pkg::phase_e phase;
    logic issued;
    logic is_mem;
    logic [core_pkg::XLEN-1:0] load_q;

    assign is_mem = (dec.op == core_pkg::OP_LW) || (dec.op == core_pkg::OP_SW);

    // one-cycle kick at the start of the fetch and mem phases
    assign fetch_start = (phase == core_pkg::PH_FETCH) && !issued;
    assign data_req    = (phase == core_pkg::PH_MEM) && !issued;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            phase  <= core_pkg::PH_FETCH;
            pc     <= core_pkg::RESET_PC;
            issued <= 1'b0;
        end else begin
            if (fetch_start || data_req) begin
                issued <= 1'b1;
            end else if (fetch_done || data_done) begin
                issued <= 1'b0;
            end
            case (phase)
                core_pkg::PH_FETCH: if (fetch_done) phase <= core_pkg::PH_EXEC;
                core_pkg::PH_EXEC:  phase <= is_mem ? core_pkg::PH_MEM : core_pkg::PH_WB;
                core_pkg::PH_MEM:   if (data_done) phase <= core_pkg::PH_WB;
                default: begin
                    pc    <= next_pc;
                    phase <= core_pkg::PH_FETCH;
                end
            endcase
        end
    end

    // load data for write-back
    always_ff @(posedge clk) begin
        if (data_done) begin
            load_q <= data_rdata;
        end
    end

    assign data_req_info = '{addr: mem_addr, wdata: rs2_data, we: dec.op == core_pkg::OP_SW};

    assign rf_wen   = (phase == core_pkg::PH_WB) && dec.writes_rd;
    assign rf_waddr = dec.rd;
    assign rf_wdata = (dec.op == core_pkg::OP_LW) ? load_q : alu_result;

    assign retire_valid = (phase == core_pkg::PH_WB);
    assign retire = '{pc: pc, rd: dec.rd, wdata: rf_wdata, wen: rf_wen};

    // mem phase is reached only through a load or store decode
    a_data_only_mem: assert property (@(posedge clk) disable iff (!arst_n)
        data_req |-> is_mem);

endmodule

//--- hw/core_top.sv
`timescale 1ns/1ps

module core_top (
    input  logic                      clk,
    input  logic                      arst_n,
    output core_pkg::mem_req_t        mem_req,
    output logic                      mem_req_valid,
    input  logic                      mem_req_ready,
    input  logic                      mem_rsp_valid,
    input  logic [core_pkg::XLEN-1:0] mem_rsp_rdata,
    output logic                      retire_valid,
    output core_pkg::retire_t         retire,
    output logic [core_pkg::XLEN-1:0] pc
);

    logic                      fetch_start;
    logic                      fetch_req;
    logic [core_pkg::XLEN-1:0] fetch_addr;
    logic                      fetch_done;
    logic [core_pkg::XLEN-1:0] lsu_rdata;
    logic [core_pkg::XLEN-1:0] inst;
    core_pkg::decoded_t        dec;
    logic [core_pkg::XLEN-1:0] rs1_data;
    logic [core_pkg::XLEN-1:0] rs2_data;
    logic [core_pkg::XLEN-1:0] alu_result;
    logic [core_pkg::XLEN-1:0] mem_addr;
    logic [core_pkg::XLEN-1:0] next_pc;
    logic                      data_req;
    core_pkg::mem_req_t        data_req_info;
    logic                      data_done;
    logic                      rf_wen;
    logic [3:0]                rf_waddr;
    logic [core_pkg::XLEN-1:0] rf_wdata;

    core_ifu u_ifu (
        .clk         (clk),
        .arst_n      (arst_n),
        .pc          (pc),
        .fetch_start (fetch_start),
        .fetch_req   (fetch_req),
        .fetch_addr  (fetch_addr),
        .fetch_done  (fetch_done),
        .fetch_rdata (lsu_rdata),
        .inst        (inst)
    );

    core_idu u_idu (
        .inst (inst),
        .dec  (dec)
    );

    core_regfile u_regfile (
        .clk    (clk),
        .arst_n (arst_n),
        .raddr1 (dec.rs1),
        .raddr2 (dec.rs2),
        .rdata1 (rs1_data),
        .rdata2 (rs2_data),
        .wen    (rf_wen),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata)
    );

    // branch decision is folded into next_pc
    core_exu u_exu (
        .dec        (dec),
        .pc         (pc),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .alu_result (alu_result),
        .mem_addr   (mem_addr),
        .taken      (),
        .next_pc    (next_pc)
    );

    core_lsu u_lsu (
        .clk           (clk),
        .arst_n        (arst_n),
        .fetch_req     (fetch_req),
        .fetch_addr    (fetch_addr),
        .fetch_done    (fetch_done),
        .data_req      (data_req),
        .data_req_info (data_req_info),
        .data_done     (data_done),
        .rdata         (lsu_rdata),
        .mem_req       (mem_req),
        .mem_req_valid (mem_req_valid),
        .mem_req_ready (mem_req_ready),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_rdata (mem_rsp_rdata)
    );

    core_pcu u_pcu (
        .clk           (clk),
        .arst_n        (arst_n),
        .dec           (dec),
        .alu_result    (alu_result),
        .mem_addr      (mem_addr),
        .rs2_data      (rs2_data),
        .next_pc       (next_pc),
        .fetch_start   (fetch_start),
        .fetch_done    (fetch_done),
        .data_req      (data_req),
        .data_req_info (data_req_info),
        .data_done     (data_done),
        .data_rdata    (lsu_rdata),
        .pc            (pc),
        .rf_wen        (rf_wen),
        .rf_waddr      (rf_waddr),
        .rf_wdata      (rf_wdata),
        .retire_valid  (retire_valid),
        .retire        (retire)
    );

endmodule

//--- verif/tb_core_top.sv
`timescale 1ns/1ps

module tb_core_top;

    localparam int RETIRES = 30;
    localparam int TIMEOUT_CYCLES = 200 * RETIRES;

    logic                      clk;
    logic                      arst_n;
    core_pkg::mem_req_t        mem_req;
    logic                      mem_req_valid;
    logic                      mem_req_ready;
    logic                      mem_rsp_valid;
    logic [core_pkg::XLEN-1:0] mem_rsp_rdata;
    logic                      retire_valid;
    core_pkg::retire_t         retire;
    logic [core_pkg::XLEN-1:0] pc;

    // memory model state
    logic [31:0] mem [1024];
    integer      seed;
    bit          stall_mode;
    int          rsp_wait;
    logic [31:0] rsp_data;
    int          reset_cycles;
    bit          store_seen;
    logic [31:0] store_addr;
    logic [31:0] store_data;

    // ISA state of the reference model
    logic [31:0] ref_pc;
    logic [31:0] ref_regs [16];
    logic [31:0] ref_mem [1024];
    bit          exp_store;
    logic [31:0] exp_addr;
    logic [31:0] exp_data;

    core_pkg::retire_t expected;
    core_pkg::retire_t first_run [$];
    int run_idx;
    int retire_count;
    int cycles;
    int mismatches;
    int other_errors;

    core_top UUT (
        .clk           (clk),
        .arst_n        (arst_n),
        .mem_req       (mem_req),
        .mem_req_valid (mem_req_valid),
        .mem_req_ready (mem_req_ready),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_rdata (mem_rsp_rdata),
        .retire_valid  (retire_valid),
        .retire        (retire),
        .pc            (pc)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // instruction encoders
    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
            input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic logic [31:0] i_type(input logic [6:0] opc, input logic [2:0] f3,
            input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] s_type(input logic [4:0] rs1, input logic [4:0] rs2,
            input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] b_type(input logic [2:0] f3, input logic [4:0] rs1,
            input logic [4:0] rs2, input logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic logic [31:0] u_type(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, 7'h37};
    endfunction

    function automatic logic [31:0] j_type(input logic [4:0] rd, input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
    endfunction

    // program in both memories, reference state back to reset
    task automatic load_program();
        for (int i = 0; i < 1024; i++) begin
            mem[i] = 32'ha5a5_0000 | i;
        end
        mem[0]  = u_type(5'd1, 20'h12345);
        mem[1]  = i_type(7'h13, 3'd0, 5'd2, 5'd0, 12'd100);
        mem[2]  = i_type(7'h13, 3'd0, 5'd3, 5'd2, 12'hff9);
        mem[3]  = i_type(7'h13, 3'd7, 5'd4, 5'd3, 12'h0f0);
        mem[4]  = i_type(7'h13, 3'd6, 5'd5, 5'd2, 12'h300);
        mem[5]  = i_type(7'h13, 3'd4, 5'd6, 5'd5, 12'hfff);
        mem[6]  = r_type(7'h00, 3'd0, 5'd7, 5'd1, 5'd2);
        mem[7]  = r_type(7'h20, 3'd0, 5'd8, 5'd2, 5'd3);
        mem[8]  = r_type(7'h00, 3'd7, 5'd9, 5'd1, 5'd6);
        mem[9]  = r_type(7'h00, 3'd6, 5'd10, 5'd3, 5'd5);
        mem[10] = r_type(7'h00, 3'd4, 5'd11, 5'd6, 5'd7);
        mem[11] = r_type(7'h00, 3'd2, 5'd12, 5'd6, 5'd2);
        mem[12] = r_type(7'h00, 3'd2, 5'd13, 5'd2, 5'd6);
        // write to x0
        mem[13] = i_type(7'h13, 3'd0, 5'd0, 5'd2, 12'd5);
        mem[14] = i_type(7'h13, 3'd0, 5'd14, 5'd0, 12'h400);
        mem[15] = s_type(5'd14, 5'd7, 12'd8);
        mem[16] = s_type(5'd14, 5'd11, 12'hffc);
        mem[17] = i_type(7'h03, 3'd2, 5'd15, 5'd14, 12'd8);
        mem[18] = i_type(7'h03, 3'd2, 5'd1, 5'd14, 12'hffc);
        mem[19] = b_type(3'd0, 5'd15, 5'd7, 13'd8);
        mem[20] = i_type(7'h13, 3'd0, 5'd2, 5'd0, 12'd1);
        mem[21] = b_type(3'd0, 5'd2, 5'd3, 13'd8);
        mem[22] = b_type(3'd1, 5'd2, 5'd3, 13'd8);
        mem[23] = i_type(7'h13, 3'd0, 5'd2, 5'd0, 12'd2);
        mem[24] = b_type(3'd1, 5'd15, 5'd7, 13'd8);
        mem[25] = j_type(5'd5, 21'd8);
        mem[26] = i_type(7'h13, 3'd0, 5'd2, 5'd0, 12'd3);
        mem[27] = 32'hffff_ffff;
        // x16 does not exist in RV32E
        mem[28] = r_type(7'h00, 3'd0, 5'd16, 5'd1, 5'd2);
        mem[29] = j_type(5'd0, 21'd8);
        mem[31] = i_type(7'h03, 3'd2, 5'd9, 5'd14, 12'd16);
        // loop back to the fill word at 30
        mem[32] = b_type(3'd0, 5'd0, 5'd0, 13'h1ff8);
        for (int i = 0; i < 1024; i++) begin
            ref_mem[i] = mem[i];
        end
        for (int i = 0; i < 16; i++) begin
            ref_regs[i] = '0;
        end
        ref_pc = core_pkg::RESET_PC;
        store_seen = 1'b0;
    endtask

    // executes one instruction on the ISA state, returns its retire record
    function automatic core_pkg::retire_t step_model();
        logic [31:0] inst;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] imm_b;
        logic [31:0] imm_j;
        logic [31:0] val;
        logic [31:0] npc;
        logic [31:0] addr;
        logic        wr;
        logic        bad;
        core_pkg::retire_t r;
        inst  = ref_mem[ref_pc[11:2]];
        rd    = inst[11:7];
        rs1   = inst[19:15];
        rs2   = inst[24:20];
        a     = ref_regs[rs1[3:0]];
        b     = ref_regs[rs2[3:0]];
        imm_i = {{20{inst[31]}}, inst[31:20]};
        imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
        imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
        imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
        val   = '0;
        wr    = 1'b0;
        bad   = 1'b0;
        addr  = '0;
        npc   = ref_pc + 32'd4;
        exp_store = 1'b0;
        case (inst[6:0])
            7'h37: begin
                val = {inst[31:12], 12'h000};
                wr  = 1'b1;
                bad = rd[4];
            end
            7'h6f: begin
                val = ref_pc + 32'd4;
                npc = ref_pc + imm_j;
                wr  = 1'b1;
                bad = rd[4];
            end
            7'h13: begin
                wr  = 1'b1;
                bad = rd[4] | rs1[4];
                case (inst[14:12])
                    3'd0: val = a + imm_i;
                    3'd4: val = a ^ imm_i;
                    3'd6: val = a | imm_i;
                    3'd7: val = a & imm_i;
                    default: bad = 1'b1;
                endcase
            end
            7'h33: begin
                wr  = 1'b1;
                bad = rd[4] | rs1[4] | rs2[4];
                case ({inst[31:25], inst[14:12]})
                    {7'h00, 3'd0}: val = a + b;
                    {7'h20, 3'd0}: val = a - b;
                    {7'h00, 3'd2}: val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    {7'h00, 3'd4}: val = a ^ b;
                    {7'h00, 3'd6}: val = a | b;
                    {7'h00, 3'd7}: val = a & b;
                    default: bad = 1'b1;
                endcase
            end
            7'h03: begin
                wr   = 1'b1;
                bad  = rd[4] | rs1[4] | (inst[14:12] != 3'd2);
                addr = a + imm_i;
                val  = ref_mem[addr[11:2]];
            end
            7'h23: begin
                bad  = rs1[4] | rs2[4] | (inst[14:12] != 3'd2);
                addr = a + imm_s;
                exp_store = 1'b1;
            end
            7'h63: begin
                bad = rs1[4] | rs2[4] | (inst[14:13] != 2'd0);
                // funct3 bit 0 inverts the equality test for BNE
                if ((a == b) != inst[12]) begin
                    npc = ref_pc + imm_b;
                end
            end
            default: bad = 1'b1;
        endcase
        if (bad) begin
            wr  = 1'b0;
            npc = ref_pc + 32'd4;
            exp_store = 1'b0;
        end
        if (exp_store) begin
            ref_mem[addr[11:2]] = b;
            exp_addr = addr;
            exp_data = b;
        end
        wr = wr && (rd != 5'd0);
        if (wr) begin
            ref_regs[rd[3:0]] = val;
        end
        r.pc    = ref_pc;
        r.rd    = rd[3:0];
        r.wdata = val;
        r.wen   = wr;
        ref_pc  = npc;
        return r;
    endfunction

    // memory: ready and response driven on the falling edge
    always @(negedge clk) begin
        mem_rsp_valid = 1'b0;
        if (!arst_n) begin
            mem_req_ready = 1'b0;
            rsp_wait = 0;
            // first reset edge may race the async clear
            if (reset_cycles > 0) begin
                assert (!mem_req_valid) else begin
                    other_errors++;
                    $display("ERROR: mem_req_valid is high while reset is asserted");
                end
            end
            reset_cycles++;
        end else begin
            reset_cycles = 0;
            if (rsp_wait > 0) begin
                rsp_wait--;
                if (rsp_wait == 0) begin
                    mem_rsp_valid = 1'b1;
                    mem_rsp_rdata = rsp_data;
                end
            end
            mem_req_ready = stall_mode ? (($random(seed) & 3) != 0) : 1'b1;
            // valid and ready both high, transfer on the next rising edge
            if (mem_req_valid && mem_req_ready) begin
                if (mem_req.we) begin
                    mem[mem_req.addr[11:2]] = mem_req.wdata;
                    store_seen = 1'b1;
                    store_addr = mem_req.addr;
                    store_data = mem_req.wdata;
                    rsp_data = '0;
                end else begin
                    rsp_data = mem[mem_req.addr[11:2]];
                end
                rsp_wait = stall_mode ? 1 + ($random(seed) & 3) : 1;
            end
        end
    end

    // compare each retire against the reference model
    always @(negedge clk) begin
        if (arst_n && retire_valid) begin
            expected = step_model();
            assert (retire.pc == expected.pc) else begin
                mismatches++;
                $display("MISMATCH retire.pc expected %h got %h", expected.pc, retire.pc);
            end
            assert (pc == expected.pc) else begin
                mismatches++;
                $display("MISMATCH pc expected %h got %h", expected.pc, pc);
            end
            assert (retire.wen == expected.wen) else begin
                mismatches++;
                $display("MISMATCH retire.wen at pc %h expected %h got %h",
                         expected.pc, expected.wen, retire.wen);
            end
            if (expected.wen) begin
                assert (retire.rd == expected.rd) else begin
                    mismatches++;
                    $display("MISMATCH retire.rd at pc %h expected %h got %h",
                             expected.pc, expected.rd, retire.rd);
                end
                assert (retire.wdata == expected.wdata) else begin
                    mismatches++;
                    $display("MISMATCH retire.wdata at pc %h expected %h got %h",
                             expected.pc, expected.wdata, retire.wdata);
                end
            end
            if (exp_store) begin
                assert (store_seen) else begin
                    other_errors++;
                    $display("ERROR: store at pc %h sent no write to memory", expected.pc);
                end
                if (store_seen) begin
                    assert (store_addr == exp_addr) else begin
                        mismatches++;
                        $display("MISMATCH mem_req.addr expected %h got %h",
                                 exp_addr, store_addr);
                    end
                    assert (store_data == exp_data) else begin
                        mismatches++;
                        $display("MISMATCH mem_req.wdata expected %h got %h",
                                 exp_data, store_data);
                    end
                end
            end else begin
                assert (!store_seen) else begin
                    other_errors++;
                    $display("ERROR: memory write from the non-store at pc %h", expected.pc);
                end
            end
            store_seen = 1'b0;
            // stalled run must retire exactly like the zero-stall run
            if (run_idx == 0) begin
                first_run.push_back(retire);
            end else if (retire_count < first_run.size()) begin
                assert (retire == first_run[retire_count]) else begin
                    mismatches++;
                    $display("MISMATCH retire expected %h got %h",
                             first_run[retire_count], retire);
                end
            end
            retire_count++;
        end
    end

    initial begin
        seed          = 32'h72eb;
        arst_n        = 1'b0;
        mem_req_ready = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_rsp_rdata = '0;
        stall_mode    = 1'b0;
        for (run_idx = 0; run_idx < 2; run_idx++) begin
            // run 0 without stalls, run 1 with random ready and delay
            stall_mode = (run_idx == 1);
            arst_n = 1'b0;
            load_program();
            retire_count = 0;
            repeat (4) @(negedge clk);
            arst_n = 1'b1;
            cycles = 0;
            while (retire_count < RETIRES && cycles < TIMEOUT_CYCLES) begin
                @(negedge clk);
                cycles++;
            end
            if (retire_count < RETIRES) begin
                other_errors++;
                $display("ERROR: core stopped retiring, %0d of %0d retires after %0d cycles",
                         retire_count, RETIRES, cycles);
                break;
            end
        end
        $display("errors: %0d mismatches, %0d other failures", mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- sources.f
hw/core_pkg.sv
hw/core_ifu.sv
hw/core_idu.sv
hw/core_regfile.sv
hw/core_exu.sv
hw/core_lsu.sv
hw/core_pcu.sv
hw/core_top.sv
verif/tb_core_top.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module tb_core_top -f sources.f -o sim_core

if ! ./obj_dir/sim_core > sim.log 2>&1; then
    cat sim.log
    echo "simulator exited with an error"
    exit 1
fi
cat sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
    exit 1
fi
grep -q "Simulation finished: PASS" sim.log
